// ==== src/lnk_pkg.sv ====
// Word layouts and constants shared by the link transmit path
// Every link word is 64 bits and both CRCs run MSB first
// Reserved fields must be sent as zero
`default_nettype none

package lnk_pkg;

   // -------------------------------------------------------------------------
   // Link geometry and fixed patterns
   // -------------------------------------------------------------------------
   localparam int WORD_W     = 64;  // Bits per link word
   localparam int DATA_SLOTS = 6;   // User slots following each boundary slot

   localparam logic [WORD_W-1:0] IDLE_WORD  = 64'h0707_0707_0707_0707;
   localparam logic [7:0]        WORD_COMMA = 8'hBC;  // Word alignment marker
   localparam logic [7:0]        BYTE_COMMA = 8'hF7;  // Byte alignment marker

   // CRC-16 over a data slot pair, 128 bits, first word first
   localparam logic [15:0] CRC16_POLY = 16'h1021;
   localparam logic [15:0] CRC16_INIT = 16'hFFFF;

   // CRC-8 over VD bits 63 to 8
   localparam logic [7:0]  CRC8_POLY  = 8'h07;
   localparam logic [7:0]  CRC8_INIT  = 8'h00;

   // -------------------------------------------------------------------------
   // Boundary word layouts
   // -------------------------------------------------------------------------

   // Frame alignment word
   typedef struct packed {
      logic        rx_rdy;      // Local receiver ready
      logic [22:0] rsvd_62_40;
      logic [7:0]  word_comma;
      logic [23:0] rsvd_31_8;
      logic [7:0]  byte_comma;
   } lnk_faw_t;

   // Validation word, covers the six slots sent before it
   typedef struct packed {
      logic [15:0]           crc45;   // Pair of data slots 4 and 5
      logic [15:0]           crc23;   // Pair of data slots 2 and 3
      logic [15:0]           crc01;   // Pair of data slots 0 and 1
      logic [1:0]            rsvd_15_14;
      logic [DATA_SLOTS-1:0] valids;  // Bit k set when slot k held user data
      logic [7:0]            crcvw;   // Protects bits 63 to 8 of this word
   } lnk_vd_t;

   // One link word seen as FAW, as VD or as plain bits
   typedef union packed {
      lnk_faw_t          faw;
      lnk_vd_t           vd;
      logic [WORD_W-1:0] raw;
   } lnk_word_u;

endpackage

`default_nettype wire

// ==== src/lnk_crc_if.sv ====
// Stage-0 word and boundary flags to the CRC engine, results back
// Boundary flags are one cycle late so they line up with the word
`default_nettype none

interface lnk_crc_if;

   import lnk_pkg::*;

   // Packet generator side
   lnk_word_u   word;          // Stage-0 register
   logic        faw_boundary;  // Word is a FAW
   logic        crc_boundary;  // Word is a VD

   // CRC engine side
   logic [15:0] crc01;
   logic [15:0] crc23;
   logic [15:0] crc45;
   logic [7:0]  crcvw;
   logic        crc_valid;     // High while the VD sits in stage 1

   modport gen (
      output word, faw_boundary, crc_boundary,
      input  crc01, crc23, crc45, crcvw, crc_valid
   );

   modport crc (
      input  word, faw_boundary, crc_boundary,
      output crc01, crc23, crc45, crcvw, crc_valid
   );

endinterface

`default_nettype wire

// ==== src/lnk_boundary_gen.sv ====
// Free-running block framing, seven slots per block
// First cycle after reset is slot 0 of block 0, always a FAW
// FAW_EVERY must be 2 or more
`default_nettype none

module lnk_boundary_gen #(
   parameter int FAW_EVERY = 4  // Blocks per FAW
) (
   input  logic clk_i,
   input  logic rst_n_i,
   output logic faw_boundary_o,  // Slot 0 of a FAW block
   output logic crc_boundary_o   // Slot 0 of any other block
);

   import lnk_pkg::*;

   localparam int SLOTS = DATA_SLOTS + 1;  // Boundary slot plus data slots
   localparam int BLK_W = (FAW_EVERY > 1) ? $clog2(FAW_EVERY) : 1;

   logic [2:0]       slot_q;     // 0 to SLOTS-1
   logic [BLK_W-1:0] blk_q;      // 0 to FAW_EVERY-1
   logic             slot_last;

   assign slot_last = (slot_q == 3'(SLOTS - 1));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         slot_q <= '0;
         blk_q  <= '0;
      end else begin
         slot_q <= slot_last ? 3'd0 : slot_q + 3'd1;
         if (slot_last) begin  // Block rolls over with the slot counter
            blk_q <= (blk_q == BLK_W'(FAW_EVERY - 1)) ? '0 : blk_q + BLK_W'(1);
         end
      end
   end

   // Exactly one strobe in slot 0, none elsewhere
   assign faw_boundary_o = (slot_q == 3'd0) && (blk_q == '0);
   assign crc_boundary_o = (slot_q == 3'd0) && (blk_q != '0);

endmodule

`default_nettype wire

// ==== src/lnk_crc_compute.sv ====
// CRC engine working on the stage-0 word of the packet generator
// Pair CRCs hold until the next pair of the same index completes
// crcvw is only meaningful while crc_valid is high
`default_nettype none

module lnk_crc_compute (
   input logic    clk_i,
   input logic    rst_n_i,
   lnk_crc_if.crc crc_if
);

   import lnk_pkg::*;

   logic [2:0]            ptr_q;        // Data slot of the current word
   logic                  bnd;          // Boundary word in stage 0
   logic                  in_data;      // Word counts towards a pair
   logic [15:0]           crc_base;
   logic [15:0]           crc_nxt;
   logic [15:0]           crc_run_q;    // Result after first word of pair
   logic [15:0]           crc01_q;
   logic [15:0]           crc23_q;
   logic [15:0]           crc45_q;
   logic [DATA_SLOTS-1:0] valids_q;     // Valids of the VD now in stage 1
   logic                  crc_valid_q;
   lnk_vd_t               vw;           // VD fields covered by the CRC-8

   // CRC-16 advanced over one full word, MSB first
   function automatic logic [15:0] crc16_word(input logic [15:0]       crc_in,
                                              input logic [WORD_W-1:0] data);
      logic [15:0] crc;
      logic        fb;
      crc = crc_in;
      for (int i = WORD_W - 1; i >= 0; i--) begin
         fb  = crc[15] ^ data[i];
         crc = {crc[14:0], 1'b0} ^ (fb ? CRC16_POLY : 16'h0000);
      end
      return crc;
   endfunction

   // CRC-8 over the 56 upper VD bits, MSB first
   function automatic logic [7:0] crc8_bits(input logic [55:0] data);
      logic [7:0] crc;
      logic       fb;
      crc = CRC8_INIT;
      for (int i = 55; i >= 0; i--) begin
         fb  = crc[7] ^ data[i];
         crc = {crc[6:0], 1'b0} ^ (fb ? CRC8_POLY : 8'h00);
      end
      return crc;
   endfunction

   assign bnd      = crc_if.faw_boundary || crc_if.crc_boundary;
   assign in_data  = !bnd && (ptr_q < 3'(DATA_SLOTS));
   assign crc_base = ptr_q[0] ? crc_run_q : CRC16_INIT;  // Even slot seeds a pair
   assign crc_nxt  = crc16_word(crc_base, crc_if.word.raw);

   // Slot pointer, restarted by every boundary word
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ptr_q <= '0;
      end else if (bnd) begin
         ptr_q <= '0;
      end else if (in_data) begin
         ptr_q <= ptr_q + 3'd1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (in_data) begin
         crc_run_q <= crc_nxt;
         if (ptr_q[0]) begin  // Odd slot closes its pair
            case (ptr_q[2:1])
               2'd0:    crc01_q <= crc_nxt;
               2'd1:    crc23_q <= crc_nxt;
               default: crc45_q <= crc_nxt;
            endcase
         end
      end
      if (crc_if.crc_boundary) begin
         valids_q <= crc_if.word.vd.valids;  // Kept for the stage-1 cycle
      end
   end

   // VD reaches stage 1 one cycle after it is seen here
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         crc_valid_q <= 1'b0;
      end else begin
         crc_valid_q <= crc_if.crc_boundary;
      end
   end

   always_comb begin
      vw.crc45      = crc45_q;
      vw.crc23      = crc23_q;
      vw.crc01      = crc01_q;
      vw.rsvd_15_14 = 2'b00;
      vw.valids     = valids_q;
      vw.crcvw      = 8'h00;  // Not covered
   end

   assign crc_if.crc01     = crc01_q;
   assign crc_if.crc23     = crc23_q;
   assign crc_if.crc45     = crc45_q;
   assign crc_if.crcvw     = crc8_bits(vw[63:8]);
   assign crc_if.crc_valid = crc_valid_q;

endmodule

`default_nettype wire

// ==== src/lnk_tx_packet_gen.sv ====
// Three-stage transmit word pipeline, fixed latency of three cycles
// Off state is neither tx_active_i nor tx_idle_i high
// Output never stalls; missing user data is filled with IDLE_WORD
`default_nettype none

module lnk_tx_packet_gen (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic                       faw_boundary_i,
   input  logic                       crc_boundary_i,
   input  logic [lnk_pkg::WORD_W-1:0] s_axis_tdata_i,
   input  logic                       s_axis_tvalid_i,
   output logic                       s_axis_tready_o,
   output logic [lnk_pkg::WORD_W-1:0] m_axis_tdata_o,
   output logic                       m_axis_tdata_isfaw_o,
   input  logic                       tx_idle_i,
   input  logic                       tx_active_i,
   input  logic                       rx_rdy_i,
   lnk_crc_if.gen                     crc_if
);

   import lnk_pkg::*;

   logic                  bnd_en;        // Boundary words allowed
   logic                  data_en;       // User data allowed
   logic                  take;          // User word accepted this cycle
   logic [1:0]            bnd_en_pipe;   // bnd_en beside stages 0 and 1
   logic [2:0]            slot_ptr_q;    // Data slot within the block
   logic [DATA_SLOTS-1:0] valid_mask_q;
   logic                  faw_bnd_q;
   logic                  crc_bnd_q;
   lnk_word_u             faw_w;
   lnk_word_u             vd_w;
   lnk_word_u             vd_fin;        // VD with finished CRCs
   lnk_word_u             word_nxt;
   lnk_word_u             word_s0;
   lnk_word_u             word_s1;
   lnk_word_u             word_s2;
   logic                  isfaw_s0;
   logic                  isfaw_s1;
   logic                  isfaw_s2;

   assign bnd_en          = tx_active_i || tx_idle_i;
   assign data_en         = tx_active_i;
   assign s_axis_tready_o = data_en && !faw_boundary_i && !crc_boundary_i;
   assign take            = s_axis_tvalid_i && s_axis_tready_o;

   // -------------------------------------------------------------------------
   // Stage 0, word select
   // -------------------------------------------------------------------------
   always_comb begin
      faw_w.faw.rx_rdy     = rx_rdy_i;
      faw_w.faw.rsvd_62_40 = '0;
      faw_w.faw.word_comma = WORD_COMMA;
      faw_w.faw.rsvd_31_8  = '0;
      faw_w.faw.byte_comma = BYTE_COMMA;

      vd_w.vd.crc45        = '0;  // Filled in at stage 2
      vd_w.vd.crc23        = '0;
      vd_w.vd.crc01        = '0;
      vd_w.vd.rsvd_15_14   = '0;
      vd_w.vd.valids       = valid_mask_q;
      vd_w.vd.crcvw        = '0;

      if (bnd_en && faw_boundary_i) begin
         word_nxt = faw_w;
      end else if (bnd_en && crc_boundary_i) begin
         word_nxt = vd_w;
      end else if (take) begin
         word_nxt.raw = s_axis_tdata_i;
      end else begin
         word_nxt.raw = IDLE_WORD;
      end
   end

   // Slot pointer and record of slots that took user words
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         slot_ptr_q   <= '0;
         valid_mask_q <= '0;
      end else if (faw_boundary_i || crc_boundary_i) begin
         slot_ptr_q <= '0;
      end else if (slot_ptr_q < 3'(DATA_SLOTS)) begin
         slot_ptr_q               <= slot_ptr_q + 3'd1;
         valid_mask_q[slot_ptr_q] <= take;
      end
   end

   // -------------------------------------------------------------------------
   // Stages 0 to 2 registers, stage 2 swaps in the finished VD
   // -------------------------------------------------------------------------
   always_comb begin
      vd_fin.vd.crc45      = crc_if.crc45;
      vd_fin.vd.crc23      = crc_if.crc23;
      vd_fin.vd.crc01      = crc_if.crc01;
      vd_fin.vd.rsvd_15_14 = 2'b00;
      vd_fin.vd.valids     = word_s1.vd.valids;  // Mask captured at stage 0
      vd_fin.vd.crcvw      = crc_if.crcvw;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         word_s0     <= '0;
         word_s1     <= '0;
         word_s2     <= '0;
         isfaw_s0    <= 1'b0;
         isfaw_s1    <= 1'b0;
         isfaw_s2    <= 1'b0;
         bnd_en_pipe <= 2'b00;
         faw_bnd_q   <= 1'b0;
         crc_bnd_q   <= 1'b0;
      end else begin
         word_s0     <= word_nxt;
         word_s1     <= word_s0;  // Delay while the CRCs finish
         word_s2     <= (bnd_en_pipe[1] && crc_if.crc_valid) ? vd_fin : word_s1;
         isfaw_s0    <= bnd_en && faw_boundary_i;
         isfaw_s1    <= isfaw_s0;
         isfaw_s2    <= isfaw_s1;
         bnd_en_pipe <= {bnd_en_pipe[0], bnd_en};
         faw_bnd_q   <= faw_boundary_i;  // Aligned with word_s0
         crc_bnd_q   <= crc_boundary_i;
      end
   end

   assign crc_if.word         = word_s0;
   assign crc_if.faw_boundary = faw_bnd_q;
   assign crc_if.crc_boundary = crc_bnd_q;

   assign m_axis_tdata_o       = word_s2.raw;
   assign m_axis_tdata_isfaw_o = isfaw_s2;

endmodule

`default_nettype wire

// ==== src/lnk_tx_top.sv ====
// Transmit framing path top level
// Words leave three cycles after selection, with no back-pressure
`default_nettype none

module lnk_tx_top #(
   parameter int FAW_EVERY = 4  // Blocks per FAW, 2 or more
) (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic [lnk_pkg::WORD_W-1:0] s_axis_tdata_i,
   input  logic                       s_axis_tvalid_i,
   output logic                       s_axis_tready_o,
   output logic [lnk_pkg::WORD_W-1:0] m_axis_tdata_o,
   output logic                       m_axis_tdata_isfaw_o,
   input  logic                       tx_idle_i,
   input  logic                       tx_active_i,
   input  logic                       rx_rdy_i
);

   logic faw_boundary;  // Slot 0 strobes
   logic crc_boundary;

   lnk_crc_if crc_if ();  // Generator to CRC engine

   lnk_boundary_gen #(
      .FAW_EVERY (FAW_EVERY)
   ) boundary_gen_inst (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .faw_boundary_o (faw_boundary),
      .crc_boundary_o (crc_boundary)
   );

   lnk_tx_packet_gen packet_gen_inst (
      .clk_i                (clk_i),
      .rst_n_i              (rst_n_i),
      .faw_boundary_i       (faw_boundary),
      .crc_boundary_i       (crc_boundary),
      .s_axis_tdata_i       (s_axis_tdata_i),
      .s_axis_tvalid_i      (s_axis_tvalid_i),
      .s_axis_tready_o      (s_axis_tready_o),
      .m_axis_tdata_o       (m_axis_tdata_o),
      .m_axis_tdata_isfaw_o (m_axis_tdata_isfaw_o),
      .tx_idle_i            (tx_idle_i),
      .tx_active_i          (tx_active_i),
      .rx_rdy_i             (rx_rdy_i),
      .crc_if               (crc_if.gen)
   );

   lnk_crc_compute crc_compute_inst (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .crc_if  (crc_if.crc)
   );

endmodule

`default_nettype wire

// ==== tests/lnk_tx_assertions.sv ====
// Protocol checks bound into the packet generator
// All checks are held off while reset is low
`default_nettype none

module lnk_tx_assertions (
   input logic                       clk_i,
   input logic                       rst_n_i,
   input logic                       faw_boundary_i,
   input logic                       crc_boundary_i,
   input logic                       tready_i,
   input logic                       isfaw_i,
   input logic [lnk_pkg::WORD_W-1:0] tdata_i
);

   import lnk_pkg::*;

   lnk_word_u out_w;  // Output word seen through the FAW layout

   assign out_w.raw = tdata_i;

   // No user word may be taken in slot 0
   tready_off_on_boundary : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (faw_boundary_i || crc_boundary_i) |-> !tready_i
   ) else $error("s_axis_tready_o high in a boundary slot");

   strobes_exclusive : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(faw_boundary_i && crc_boundary_i)
   ) else $error("FAW and CRC boundary strobes high together");

   // A flagged FAW must carry both alignment patterns
   faw_commas : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      isfaw_i |-> (out_w.faw.word_comma == WORD_COMMA) &&
                  (out_w.faw.byte_comma == BYTE_COMMA)
   ) else $error("FAW flagged on a word without the comma fields");

endmodule

bind lnk_tx_packet_gen lnk_tx_assertions lnk_tx_assertions_inst (
   .clk_i          (clk_i),
   .rst_n_i        (rst_n_i),
   .faw_boundary_i (faw_boundary_i),
   .crc_boundary_i (crc_boundary_i),
   .tready_i       (s_axis_tready_o),
   .isfaw_i        (m_axis_tdata_isfaw_o),
   .tdata_i        (m_axis_tdata_o)
);

`default_nettype wire

// ==== tests/lnk_tx_tb.sv ====
// Directed testbench for the link transmit framing path
// Model tracks slots from reset and predicts each output three cycles ahead
// Inputs change on the falling edge and checks run 2 time units later
`default_nettype none

module lnk_tx_tb;

   import lnk_pkg::*;

   localparam int FAW_EVERY = 4;
   localparam int MAX_TIME  = 50000;  // Watchdog for the whole run

   logic        clk;
   logic        rst_n;
   logic [63:0] s_tdata;
   logic        s_tvalid;
   logic        s_tready;
   logic [63:0] m_tdata;
   logic        m_isfaw;
   logic        tx_active;
   logic        tx_idle;
   logic        rx_rdy;

   int          errors;
   int          slot;               // Model slot, 0 is the boundary
   int          blk;                // Model block within the FAW period
   logic [63:0] blk_words [6];      // Words sent in the data slots of this block
   logic [5:0]  blk_valids;         // Data slots that took a user word
   logic [63:0] exp_data_q [$];     // Predicted outputs, oldest first
   logic        exp_faw_q [$];
   logic [63:0] offer_q [$];        // User words waiting to be taken

   lnk_tx_top #(
      .FAW_EVERY (FAW_EVERY)
   ) lnk_tx_top_inst (
      .clk_i                (clk),
      .rst_n_i              (rst_n),
      .s_axis_tdata_i       (s_tdata),
      .s_axis_tvalid_i      (s_tvalid),
      .s_axis_tready_o      (s_tready),
      .m_axis_tdata_o       (m_tdata),
      .m_axis_tdata_isfaw_o (m_isfaw),
      .tx_idle_i            (tx_idle),
      .tx_active_i          (tx_active),
      .rx_rdy_i             (rx_rdy)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(MAX_TIME);
      $display("Timeout: run still going after %0d time units", MAX_TIME);
      $display("Errors found");
      $finish;
   end

   // -------------------------------------------------------------------------
   // Reference model
   // -------------------------------------------------------------------------
   function automatic logic [15:0] crc16_pair(input logic [127:0] bits);
      logic [15:0] c;
      c = CRC16_INIT;
      for (int i = 127; i >= 0; i--) begin  // First word first and MSB first
         if (c[15] != bits[i]) begin
            c = (c << 1) ^ CRC16_POLY;
         end else begin
            c = c << 1;
         end
      end
      return c;
   endfunction

   function automatic logic [7:0] crc8_fields(input logic [55:0] bits);
      logic [7:0] c;
      c = CRC8_INIT;
      for (int i = 55; i >= 0; i--) begin
         if (c[7] != bits[i]) begin
            c = (c << 1) ^ CRC8_POLY;
         end else begin
            c = c << 1;
         end
      end
      return c;
   endfunction

   // VD over the six words the model sent in the block just ended
   function automatic logic [63:0] make_vd();
      logic [15:0] pair_crc [3];
      logic [55:0] fields;
      for (int p = 0; p < 3; p++) begin
         pair_crc[p] = crc16_pair({blk_words[2*p], blk_words[2*p+1]});
      end
      fields = {pair_crc[2], pair_crc[1], pair_crc[0], 2'b00, blk_valids};
      return {fields, crc8_fields(fields)};
   endfunction

   task automatic report_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
      errors++;
      $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
   endtask

   task automatic model_cycle(output logic taken);
      logic        exp_rdy;
      logic        bnd_en;
      logic        exp_faw;
      logic [63:0] exp_w;
      // Output shows the decision of three cycles ago
      assert (m_tdata === exp_data_q[0])
         else report_value("m_axis_tdata_o", exp_data_q[0], m_tdata);
      assert (m_isfaw === exp_faw_q[0])
         else report_value("m_axis_tdata_isfaw_o", 64'(exp_faw_q[0]), 64'(m_isfaw));
      void'(exp_data_q.pop_front());
      void'(exp_faw_q.pop_front());
      exp_rdy = tx_active && (slot != 0);
      bnd_en  = tx_active || tx_idle;          // Off sends idle words only
      taken   = s_tvalid && exp_rdy;
      exp_faw = bnd_en && (slot == 0) && (blk == 0);
      assert (s_tready === exp_rdy)
         else report_value("s_axis_tready_o", 64'(exp_rdy), 64'(s_tready));
      if (exp_faw) begin
         exp_w = {rx_rdy, 23'd0, WORD_COMMA, 24'd0, BYTE_COMMA};
      end else if (bnd_en && (slot == 0)) begin
         exp_w = make_vd();
      end else if (taken) begin
         exp_w = s_tdata;
      end else begin
         exp_w = IDLE_WORD;
      end
      if (slot != 0) begin
         blk_words[slot-1]  = exp_w;
         blk_valids[slot-1] = taken;
      end
      exp_data_q.push_back(exp_w);
      exp_faw_q.push_back(exp_faw);
      if (slot == DATA_SLOTS) begin       // Block wraps after the last data slot
         slot = 0;
         blk  = (blk == FAW_EVERY - 1) ? 0 : blk + 1;
      end else begin
         slot++;
      end
   endtask

   // -------------------------------------------------------------------------
   // Stimulus tasks start and end on a falling edge
   // -------------------------------------------------------------------------
   task automatic step(input logic valid, input logic [63:0] data, output logic taken);
      s_tvalid = valid;
      s_tdata  = data;
      #2;
      model_cycle(taken);
      @(negedge clk);
   endtask

   task automatic drive_stream(input int unsigned valid_pct);
      logic        valid;
      logic        taken;
      logic [63:0] data;
      valid = (offer_q.size() > 0) && (($urandom % 100) < valid_pct);
      data  = {$urandom, $urandom};   // Junk when not valid
      if (valid) begin
         data = offer_q[0];
      end
      step(valid, data, taken);
      if (taken) begin
         void'(offer_q.pop_front());
      end
   endtask

   task automatic run_cycles(input int n, input int unsigned valid_pct);
      repeat (n) drive_stream(valid_pct);
   endtask

   task automatic fill_offers(input int n);
      repeat (n) offer_q.push_back({$urandom, $urandom});
   endtask

   task automatic wait_offers_taken(input int unsigned valid_pct, input int limit);
      int guard;
      guard = 0;
      while ((offer_q.size() > 0) && (guard < limit)) begin
         drive_stream(valid_pct);
         guard++;
      end
      assert (offer_q.size() == 0)
         else begin
            errors++;
            $display("Timeout at time %0t: %0d user words still waiting after %0d cycles",
                     $time, offer_q.size(), limit);
         end
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n      = 1'b1;
      slot       = 0;                     // First cycle is the FAW of block 0
      blk        = 0;
      blk_valids = '0;
      exp_data_q.delete();
      exp_faw_q.delete();
      repeat (3) begin                    // Pipeline holds reset zeros
         exp_data_q.push_back(64'd0);
         exp_faw_q.push_back(1'b0);
      end
   endtask

   // -------------------------------------------------------------------------
   // Directed tests
   // -------------------------------------------------------------------------
   task automatic off_state_quiet();
      tx_active = 1'b0;
      tx_idle   = 1'b0;
      run_cycles(2 * 7, 0);
   endtask

   task automatic idle_state_framing();
      tx_idle = 1'b1;
      run_cycles(FAW_EVERY * 7, 0);
      rx_rdy = 1'b1;                      // Next FAW shows the bit
      run_cycles(FAW_EVERY * 7, 0);
      rx_rdy = 1'b0;
   endtask

   task automatic full_stream_order();
      tx_idle   = 1'b0;
      tx_active = 1'b1;
      fill_offers(48);
      wait_offers_taken(100, 100);
      run_cycles(14, 0);                  // Flush the last VD
   endtask

   task automatic random_gap_stream();
      fill_offers(48);
      wait_offers_taken(50, 400);
      run_cycles(14, 0);
   endtask

   task automatic state_switching();
      fill_offers(36);
      run_cycles(10, 80);                 // Active into the second block
      tx_active = 1'b0;
      tx_idle   = 1'b1;
      run_cycles(5, 80);                  // Idle mid block with the stream held
      tx_active = 1'b1;
      tx_idle   = 1'b0;
      run_cycles(4, 80);
      tx_active = 1'b0;
      run_cycles(9, 80);                  // Off across a boundary
      rx_rdy    = 1'b1;
      tx_active = 1'b1;
      wait_offers_taken(80, 300);
      tx_active = 1'b0;
      tx_idle   = 1'b1;
      run_cycles(FAW_EVERY * 7 + 7, 0);
   endtask

   initial begin
      errors    = 0;
      rst_n     = 1'b0;
      s_tdata   = '0;
      s_tvalid  = 1'b0;
      tx_active = 1'b0;
      tx_idle   = 1'b0;
      rx_rdy    = 1'b0;
      void'($urandom(32'hfc51_0c4d));
      apply_reset();
      off_state_quiet();
      idle_state_framing();
      full_stream_order();
      random_gap_stream();
      state_switching();
      $display("Run complete with %0d failed check(s)", errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
src/lnk_pkg.sv
src/lnk_crc_if.sv
src/lnk_boundary_gen.sv
src/lnk_crc_compute.sv
src/lnk_tx_packet_gen.sv
src/lnk_tx_top.sv
tests/lnk_tx_assertions.sv
tests/lnk_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lnk_tx_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -j 0
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation FAILED, no pass line"; exit 1; fi
	@echo "Simulation PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
